// File: all.f
+incdir+.
taylor_pkg.sv
sample_dispatch.sv
taylor_core.sv
result_collector.sv
taylor_array.sv
tb_taylor_array.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the taylor_array testbench with Verilator

cd "$(dirname "$0")" || exit 1

TOP=tb_taylor_array
BUILD_DIR=obj_dir
LOG=sim.log

if ! command -v verilator >/dev/null 2>&1; then
	echo "verilator not found in PATH"
	exit 1
fi

rm -rf "$BUILD_DIR"
rm -f "$LOG"

verilator --binary -Wno-fatal -f all.f --top-module "$TOP" -Mdir "$BUILD_DIR"
status=$?
if [ $status -ne 0 ]; then
	echo "build failed with status $status"
	exit 1
fi

"./$BUILD_DIR/V$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "^sim passed$" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

// File: tb_taylor_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "taylor_cfg.svh"

module tb_taylor_array;

	localparam int CLK_PERIOD = 8;
	localparam int N_STREAM = 200;
	localparam int N_BACKPRESSURE = 200;
	localparam int N_EXTREME = 100;
	localparam int TOTAL_SAMPLES = 3 + N_STREAM + N_BACKPRESSURE + N_EXTREME;
	localparam int WATCHDOG_CYCLES = TOTAL_SAMPLES * (`TAY_ORDER + 3) * 8;

	localparam taylor_pkg::sample_t X_MAX = {1'b0, {(`TAY_X_W - 1){1'b1}}};
	localparam taylor_pkg::sample_t X_MIN = {1'b1, {(`TAY_X_W - 1){1'b0}}};
	localparam taylor_pkg::sample_t X_ONE = taylor_pkg::sample_t'(1 << `TAY_X_FRAC);

	logic                    clk;
	logic                    rst_n;
	logic                    in_valid;
	taylor_pkg::sample_t     in_sample;
	logic                    in_ready;
	logic                    out_valid;
	logic                    out_ready;
	taylor_pkg::taylor_out_t out_data;

	logic [31:0]             rng_state;
	taylor_pkg::sample_t     stim_q[$];
	taylor_pkg::taylor_out_t expect_q[$];   // Model results in input order
	taylor_pkg::taylor_out_t exp_item;
	taylor_pkg::taylor_out_t new_item;
	taylor_pkg::taylor_out_t fixed_item;
	taylor_pkg::taylor_out_t stall_data;
	taylor_pkg::taylor_out_t last_out;
	logic                    stall_seen;
	int                      in_count;
	int                      out_count;
	int                      pass_count;
	int                      fail_count;

	taylor_array u_taylor_array (
		.clk       (clk),
		.rst_n     (rst_n),
		.in_valid  (in_valid),
		.in_sample (in_sample),
		.in_ready  (in_ready),
		.out_valid (out_valid),
		.out_ready (out_ready),
		.out_data  (out_data)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] v;
		v = s;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	function automatic logic [31:0] next_random();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	// Sign-extend the low TAY_Y_W bits
	function automatic longint wrap_y(input longint v);
		taylor_pkg::result_t r;
		r = taylor_pkg::result_t'(v);
		return longint'(r);
	endfunction

	// exp(x) by Horner's rule starting from the highest coefficient
	function automatic taylor_pkg::result_t horner_exp(input taylor_pkg::sample_t x);
		longint acc;
		longint prod;
		acc = longint'(taylor_pkg::TAY_COEF[`TAY_ORDER]);
		for (int k = `TAY_ORDER; k >= 1; k--) begin
			prod = acc * longint'(x);
			acc = wrap_y((prod >>> `TAY_X_FRAC) + longint'(taylor_pkg::TAY_COEF[k - 1]));
		end
		return taylor_pkg::result_t'(acc);
	endfunction

	task automatic report_failure(input string msg);
		fail_count++;
		$display("ERROR at %0t: %s", $time, msg);
	endtask

	task automatic check_result(input taylor_pkg::taylor_out_t expected,
			input taylor_pkg::taylor_out_t actual, input string what);
		if (actual !== expected) begin
			fail_count++;
			$display("MISMATCH at %0t: %s expected value %0d core %0d, got value %0d core %0d",
				$time, what, expected.value, expected.core, actual.value, actual.core);
		end else begin
			pass_count++;
		end
	endtask

	task automatic check_ready(input logic expected, input logic actual, input string what);
		if (actual !== expected) begin
			fail_count++;
			$display("MISMATCH at %0t: %s expected %b, got %b", $time, what, expected, actual);
		end else begin
			pass_count++;
		end
	endtask

	task automatic report_test(input string name, input int n, input int fails_before);
		$display("test %-16s %0d samples, %0d errors", name, n, fail_count - fails_before);
	endtask

	// Handshakes are sampled at the falling edge where all signals are settled
	initial begin
		forever begin
			@(negedge clk);
			if (rst_n === 1'b1) begin
				// A held sample plus a busy core means a full rotation is in flight
				if (!in_ready && (in_count - out_count) < `TAY_NUM_CORES + 1)
					report_failure($sformatf("in_ready low with only %0d results outstanding",
						in_count - out_count));

				if (stall_seen) begin
					if (!out_valid)
						report_failure("out_valid dropped while out_ready was low");
					else
						check_result(stall_data, out_data, "held output");
				end

				if (out_valid && out_ready) begin
					if (expect_q.size() == 0) begin
						report_failure("output transfer with no sample outstanding");
					end else begin
						exp_item = expect_q.pop_front();
						check_result(exp_item, out_data, "result");
					end
					last_out = out_data;
					out_count++;
				end
				stall_seen = out_valid && !out_ready;
				stall_data = out_data;

				if (in_valid && in_ready) begin
					new_item.value = horner_exp(in_sample);
					new_item.core = taylor_pkg::core_idx_t'(in_count % `TAY_NUM_CORES);
					expect_q.push_back(new_item);
					in_count++;
				end
			end
		end
	end

	initial begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("sim failed");
		$finish;
	end

	// Feeds stim_q in order and holds each sample until it is taken
	task automatic send_samples(input int gap_pct, input int low_pct);
		int idx;
		logic took;
		idx = 0;
		took = 1'b0;
		while (idx < stim_q.size()) begin
			@(posedge clk);
			#1;
			out_ready = int'(next_random() % 100) >= low_pct;
			if (!in_valid || took) begin
				if (int'(next_random() % 100) >= gap_pct) begin
					in_valid = 1'b1;
					in_sample = stim_q[idx];
				end else begin
					in_valid = 1'b0;
				end
			end
			@(negedge clk);
			took = in_valid && in_ready;
			if (took)
				idx++;
		end
		@(posedge clk);
		#1;
		in_valid = 1'b0;
	endtask

	task automatic drain(input int low_pct);
		while (out_count != in_count) begin
			@(posedge clk);
			#1;
			out_ready = int'(next_random() % 100) >= low_pct;
		end
	endtask

	initial begin
		int fails_before;
		taylor_pkg::sample_t singles[3];
		logic [31:0] pick;

		rng_state = 32'd58736;
		in_count = 0;
		out_count = 0;
		pass_count = 0;
		fail_count = 0;
		stall_seen = 1'b0;
		rst_n = 1'b0;
		in_valid = 1'b0;
		in_sample = '0;
		out_ready = 1'b0;
		repeat (3) @(posedge clk);
		#1;
		rst_n = 1'b1;

		fails_before = fail_count;
		@(negedge clk);
		check_ready(1'b0, out_valid, "out_valid after reset");
		check_ready(1'b1, in_ready, "in_ready after reset");
		report_test("reset", 0, fails_before);

		fails_before = fail_count;
		singles[0] = '0;
		singles[1] = X_ONE;
		singles[2] = -X_ONE;
		for (int i = 0; i < 3; i++) begin
			stim_q.delete();
			stim_q.push_back(singles[i]);
			send_samples(0, 0);
			drain(0);
			if (i == 0) begin
				fixed_item.value = taylor_pkg::TAY_COEF[0];   // exp(0) is exactly 1.0
				fixed_item.core = '0;
				check_result(fixed_item, last_out, "zero sample");
			end
		end
		report_test("single_samples", 3, fails_before);

		fails_before = fail_count;
		stim_q.delete();
		for (int i = 0; i < N_STREAM; i++)
			stim_q.push_back(taylor_pkg::sample_t'(next_random()));
		send_samples(0, 0);
		drain(0);
		report_test("full_rate_stream", N_STREAM, fails_before);

		fails_before = fail_count;
		stim_q.delete();
		for (int i = 0; i < N_BACKPRESSURE; i++)
			stim_q.push_back(taylor_pkg::sample_t'(next_random()));
		send_samples(20, 40);
		drain(40);
		report_test("random_out_ready", N_BACKPRESSURE, fails_before);

		fails_before = fail_count;
		stim_q.delete();
		for (int i = 0; i < N_EXTREME; i++) begin
			pick = next_random() % 3;
			if (pick == 0)
				stim_q.push_back(X_MAX);
			else if (pick == 1)
				stim_q.push_back(X_MIN);
			else
				stim_q.push_back(taylor_pkg::sample_t'(next_random()));
		end
		send_samples(50, 30);
		drain(30);
		report_test("extreme_samples", N_EXTREME, fails_before);

		// Idle a few cycles to catch stray outputs
		@(posedge clk);
		#1;
		out_ready = 1'b1;
		repeat (2 * (`TAY_ORDER + 3)) @(posedge clk);
		if (expect_q.size() != 0)
			report_failure($sformatf("%0d results never arrived", expect_q.size()));

		$display("checks passed: %0d, failed: %0d", pass_count, fail_count);
		if (fail_count == 0)
			$display("sim passed");
		else
			$display("sim failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: taylor_array.sv
`timescale 1ns/1ps
`default_nettype none

`include "taylor_cfg.svh"

module taylor_array (
	input  wire                       clk,
	input  wire                       rst_n,
	input  wire                       in_valid,
	input  taylor_pkg::sample_t       in_sample,
	output logic                      in_ready,
	output logic                      out_valid,
	input  wire                       out_ready,
	output taylor_pkg::taylor_out_t   out_data
);

	logic [`TAY_NUM_CORES-1:0] core_in_valid;
	logic [`TAY_NUM_CORES-1:0] core_in_ready;
	logic [`TAY_NUM_CORES-1:0] core_res_valid;
	logic [`TAY_NUM_CORES-1:0] core_res_ready;

	taylor_pkg::sample_t                         core_x;    // Broadcast to all cores
	taylor_pkg::result_t [`TAY_NUM_CORES-1:0]    core_res;

	sample_dispatch u_dispatch (
		.clk           (clk),
		.rst_n         (rst_n),
		.in_valid      (in_valid),
		.in_sample     (in_sample),
		.in_ready      (in_ready),
		.core_in_valid (core_in_valid),
		.core_in_ready (core_in_ready),
		.core_x        (core_x)
	);

	for (genvar i = 0; i < `TAY_NUM_CORES; i++) begin : g_core
		taylor_core u_core (
			.clk       (clk),
			.rst_n     (rst_n),
			.in_valid  (core_in_valid[i]),
			.x         (core_x),
			.in_ready  (core_in_ready[i]),
			.res_valid (core_res_valid[i]),
			.res_ready (core_res_ready[i]),
			.res       (core_res[i])
		);
	end

	// Same rotation as the dispatcher keeps results in input order
	result_collector u_collector (
		.clk            (clk),
		.rst_n          (rst_n),
		.core_res_valid (core_res_valid),
		.core_res       (core_res),
		.core_res_ready (core_res_ready),
		.out_valid      (out_valid),
		.out_ready      (out_ready),
		.out_data       (out_data)
	);

endmodule

`default_nettype wire

// File: result_collector.sv
`timescale 1ns/1ps
`default_nettype none

`include "taylor_cfg.svh"

module result_collector (
	input  wire                                          clk,
	input  wire                                          rst_n,
	input  wire  [`TAY_NUM_CORES-1:0]                    core_res_valid,
	input  taylor_pkg::result_t [`TAY_NUM_CORES-1:0]     core_res,
	output logic [`TAY_NUM_CORES-1:0]                    core_res_ready,
	output logic                                         out_valid,
	input  wire                                          out_ready,
	output taylor_pkg::taylor_out_t                      out_data
);

	taylor_pkg::core_idx_t   rd_ptr;   // Core whose result is next in order
	taylor_pkg::taylor_out_t out_q;

	logic room;
	logic take;

	// Output register free now or freed on this edge
	assign room = !out_valid || out_ready;
	assign take = room && core_res_valid[rd_ptr];

	assign out_data = out_q;

	// Only the core at the pointer sees ready
	always_comb begin
		core_res_ready = '0;
		core_res_ready[rd_ptr] = room;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			out_valid <= 1'b0;
			rd_ptr    <= '0;
		end else begin
			if (take) begin
				out_valid <= 1'b1;
				if (rd_ptr == taylor_pkg::core_idx_t'(`TAY_NUM_CORES - 1))
					rd_ptr <= '0;
				else
					rd_ptr <= rd_ptr + 1'b1;
			end else if (out_ready) begin
				out_valid <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (take) begin
			out_q.value <= core_res[rd_ptr];
			out_q.core  <= rd_ptr;   // Tag with the producing core
		end
	end

endmodule

`default_nettype wire

// File: taylor_core.sv
`timescale 1ns/1ps
`default_nettype none

`include "taylor_cfg.svh"

module taylor_core (
	input  wire                   clk,
	input  wire                   rst_n,
	input  wire                   in_valid,
	input  taylor_pkg::sample_t   x,
	output logic                  in_ready,
	output logic                  res_valid,
	input  wire                   res_ready,
	output taylor_pkg::result_t   res
);

	localparam int CNT_W = $clog2(`TAY_ORDER + 1);

	logic               busy;
	logic [CNT_W-1:0]   cnt;        // Horner steps still to do
	logic [CNT_W-1:0]   coef_idx;

	taylor_pkg::sample_t x_q;
	taylor_pkg::result_t acc;
	taylor_pkg::result_t step;
	taylor_pkg::result_t res_q;

	logic signed [`TAY_Y_W+`TAY_X_W-1:0] prod;

	logic accept;

	// Idle means no evaluation running and no result waiting
	assign in_ready = !busy && !res_valid;
	assign accept   = in_valid && in_ready;

	// Step k adds coefficient entry k-1
	assign coef_idx = (cnt == '0) ? '0 : cnt - 1'b1;

	// acc*x scaled back to Q7.20 with truncation and wrap
	assign prod = acc * x_q;
	assign step = taylor_pkg::result_t'(prod >>> `TAY_X_FRAC) + taylor_pkg::TAY_COEF[coef_idx];

	assign res = res_q;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			busy      <= 1'b0;
			cnt       <= '0;
			res_valid <= 1'b0;
		end else begin
			if (accept) begin
				busy <= 1'b1;
				cnt  <= CNT_W'(`TAY_ORDER);
			end else if (busy) begin
				if (cnt != '0) begin
					cnt <= cnt - 1'b1;
				end else begin
					busy      <= 1'b0;   // Result moves to the output register
					res_valid <= 1'b1;
				end
			end

			if (res_valid && res_ready)
				res_valid <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			x_q <= x;
			acc <= taylor_pkg::TAY_COEF[`TAY_ORDER];   // Highest power first
		end else if (busy && cnt != '0) begin
			acc <= step;
		end

		if (busy && cnt == '0)
			res_q <= acc;
	end

endmodule

`default_nettype wire

// File: sample_dispatch.sv
`timescale 1ns/1ps
`default_nettype none

`include "taylor_cfg.svh"

module sample_dispatch (
	input  wire                           clk,
	input  wire                           rst_n,
	input  wire                           in_valid,
	input  taylor_pkg::sample_t           in_sample,
	output logic                          in_ready,
	output logic [`TAY_NUM_CORES-1:0]     core_in_valid,
	input  wire  [`TAY_NUM_CORES-1:0]     core_in_ready,
	output taylor_pkg::sample_t           core_x
);

	logic                  full;       // Holding register occupied
	taylor_pkg::sample_t   sample_q;
	taylor_pkg::core_idx_t wr_ptr;     // Core that gets the held sample

	logic hand_off;
	logic in_fire;

	// Selected core takes the held sample this cycle
	assign hand_off = full && core_in_ready[wr_ptr];

	// Accept while empty, or while the register drains on the same edge
	assign in_ready = !full || hand_off;
	assign in_fire  = in_valid && in_ready;

	assign core_x = sample_q;

	// Offer only to the core at the rotation pointer
	always_comb begin
		core_in_valid = '0;
		core_in_valid[wr_ptr] = full;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			full   <= 1'b0;
			wr_ptr <= '0;
		end else begin
			if (in_fire)
				full <= 1'b1;
			else if (hand_off)
				full <= 1'b0;

			if (hand_off) begin
				if (wr_ptr == taylor_pkg::core_idx_t'(`TAY_NUM_CORES - 1))
					wr_ptr <= '0;
				else
					wr_ptr <= wr_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (in_fire)
			sample_q <= in_sample;
	end

endmodule

`default_nettype wire

// File: taylor_pkg.sv
`default_nettype none

`include "taylor_cfg.svh"

package taylor_pkg;

	typedef logic signed [`TAY_X_W-1:0] sample_t;
	typedef logic signed [`TAY_Y_W-1:0] result_t;

	// Enough bits to name any core of the array
	typedef logic [$clog2(`TAY_NUM_CORES)-1:0] core_idx_t;

	typedef result_t coef_t;

	// One merged output word
	typedef struct packed {
		result_t   value;
		core_idx_t core;   // Core that produced the value
	} taylor_out_t;

	// 1/k! with TAY_Y_FRAC fraction bits, truncated toward zero
	localparam coef_t TAY_COEF [0:8] = '{
		coef_t'(1048576),   // 1/0!
		coef_t'(1048576),
		coef_t'(524288),
		coef_t'(174762),
		coef_t'(43690),
		coef_t'(8738),
		coef_t'(1456),
		coef_t'(208),
		coef_t'(26)         // 1/8!
	};

endpackage

`default_nettype wire

// File: taylor_cfg.svh
`ifndef TAYLOR_CFG_SVH
`define TAYLOR_CFG_SVH

// Number of cores in the array (2 to 8)
`define TAY_NUM_CORES 4

// Highest power of x in the exp series (1 to 8)
`define TAY_ORDER 6

// Samples are Q3.15 in a signed word
`define TAY_X_W 19
`define TAY_X_FRAC 15

// Results and the accumulator are Q7.20
`define TAY_Y_W 28
`define TAY_Y_FRAC 20

`endif
